// File: verilog.f
+incdir+verilog
verilog/ppu_fsm_pkg.sv
verilog/ppu_hpos_logic.sv
verilog/ppu_vpos_logic.sv
verilog/ppu_frame_ctrl.sv
verilog/ppu_fsm.sv
bench/ppu_fsm_asserts.sv
bench/ppu_fsm_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ppu_fsm_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
SIM_FLAGS ?= +verilator+error+limit+1000000
PASS_TEXT ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/ppu_fsm_tb.sv
// Testbench for the NTSC timing controller, drives decoder strobes while bound assertions check
`default_nettype none
`timescale 1ns/1ns
`include "ppu_fsm_config.svh"

module ppu_fsm_tb;

	localparam int directed_cycles = 100;
	localparam int random_cycles = 2000;
	localparam int timeout_ns = (directed_cycles + random_cycles) * 100 * 2; // Twice the run

	logic pclk = 1'b0;
	logic rst_n;
	ppu_fsm_pkg::h_decode_t hdec;
	ppu_fsm_pkg::v_decode_t vdec;
	ppu_fsm_pkg::ppu_ctrl_t ctrl;
	logic reg_read;
	logic dbe;
	ppu_fsm_pkg::sprite_ctrl_t sprite;
	ppu_fsm_pkg::fetch_ctrl_t fetch;
	logic sc_cnt;
	logic n_picture;
	logic blnk;
	logic sync;
	logic burst;
	logic hc;
	logic vc;
	logic irq;
	logic db7;
	logic db7_oe;

	int seed = 32'h5c52dd7a;
	int timeouts = 0;
	logic [31:0] rnd_a;
	logic [31:0] rnd_b;

	always #50 pclk = ~pclk;

	ppu_fsm dut0 (.*);

	bind ppu_fsm ppu_fsm_asserts asrt0 (.*);

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge pclk);
	endtask

	// One-dot strobe, back to idle on the next falling edge
	task automatic pulse_hdec(input ppu_fsm_pkg::h_decode_t strobes);
		hdec = strobes;
		@(negedge pclk);
		hdec = '0;
	endtask

	task automatic pulse_vdec(input ppu_fsm_pkg::v_decode_t strobes);
		vdec = strobes;
		@(negedge pclk);
		vdec = '0;
	endtask

	task automatic end_run();
		int fails;
		fails = dut0.asrt0.fail_cnt;
		$display("Assertion failures: %0d, timeouts: %0d", fails, timeouts);
		if (fails == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	initial begin
		hdec = '0;
		vdec = '0;
		ctrl = '0;
		reg_read = 1'b0;
		dbe = 1'b0;
		rst_n = 1'b0;
		wait_cycles(2);
		rst_n = 1'b1;

		pulse_hdec('{hb_set: 1'b1, default: 1'b0}); // Scroll update window
		wait_cycles(2);
		ctrl.black = 1'b1;
		wait_cycles(2);
		ctrl.black = 1'b0;
		pulse_hdec('{fp_set: 1'b1, bp_set: 1'b1, cb_set: 1'b1, default: 1'b0});
		pulse_hdec('{fp_set: 1'b1, fp_clr: 1'b1, default: 1'b0}); // Set wins
		wait_cycles(2);
		pulse_hdec('{fp_clr: 1'b1, bp_clr: 1'b1, default: 1'b0});

		pulse_vdec('{vs_set: 1'b1, vb_set: 1'b1, default: 1'b0}); // Inside hblank
		wait_cycles(2);
		pulse_hdec('{hb_clr: 1'b1, default: 1'b0});
		pulse_vdec('{vs_clr: 1'b1, default: 1'b0}); // Outside hblank, vsync holds
		wait_cycles(2);
		pulse_hdec('{hb_set: 1'b1, cb_clr: 1'b1, default: 1'b0});
		pulse_vdec('{vs_clr: 1'b1, blnk_clr: 1'b1, default: 1'b0});

		pulse_hdec('{sev: 1'b1, ioam: 1'b1, default: 1'b0});
		pulse_hdec('{objrd: 1'b1, eval: 1'b1, default: 1'b0});
		pulse_hdec('{eev: 1'b1, nvis: 1'b1, fnt: 1'b1, default: 1'b0});
		wait_cycles(3);
		ctrl.n_obclip = 1'b1; // Sprite clip off
		pulse_hdec('{clpb: 1'b1, default: 1'b0});
		pulse_hdec('{clpo: 1'b1, clpb: 1'b1, default: 1'b0});
		ctrl.n_obclip = 1'b0;
		ctrl.n_bgclip = 1'b1;
		pulse_hdec('{clpb: 1'b1, default: 1'b0});
		wait_cycles(3);
		ctrl.n_bgclip = 1'b0;

		pulse_hdec('{fat: 1'b1, default: 1'b0});
		pulse_hdec('{fat: 1'b1, fo_a: 1'b1, default: 1'b0});
		pulse_hdec('{fta: 1'b1, ftb: 1'b1, default: 1'b0});
		pulse_hdec('{fta: 1'b1, ftb: 1'b1, fo_b: 1'b1, default: 1'b0}); // Output fetch wins
		wait_cycles(3);

		ctrl.vbl_en = 1'b1;
		pulse_vdec('{vset: 1'b1, default: 1'b0});
		wait_cycles(3);
		reg_read = 1'b1; // Status read
		dbe = 1'b1;
		wait_cycles(1);
		reg_read = 1'b0;
		dbe = 1'b0;
		wait_cycles(2);
		pulse_vdec('{vset: 1'b1, default: 1'b0});
		wait_cycles(2);
		pulse_vdec('{vclr: 1'b1, default: 1'b0}); // Next frame is odd
		wait_cycles(3);

		pulse_hdec('{hpos: 1'b1, default: 1'b0}); // Skip dot
		wait_cycles(2);
		hdec.h_last = 1'b1;
		vdec.v_last = 1'b1;
		wait_cycles(1);
		hdec = '0;
		vdec = '0;
		pulse_vdec('{v_last: 1'b1, default: 1'b0}); // No line end, no vc
		wait_cycles(3);

		// Quarter density strobes, register bits change now and then
		repeat (random_cycles) begin
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			hdec = rnd_a[`PPU_HDEC_W-1:0] & rnd_b[`PPU_HDEC_W-1:0];
			vdec = rnd_a[31:32-`PPU_VDEC_W] & rnd_b[31:32-`PPU_VDEC_W];
			reg_read = rnd_b[1];
			dbe = rnd_a[0] & rnd_b[0];
			if (rnd_b[31:29] == 3'b000) begin
				ctrl = rnd_a[3:0];
			end
			wait_cycles(1);
		end
		hdec = '0;
		vdec = '0;
		reg_read = 1'b0;
		dbe = 1'b0;
		wait_cycles(4);
		end_run();
	end

	initial begin
		#(timeout_ns);
		timeouts++;
		$display("Timeout: the run did not finish within %0d ns", timeout_ns);
		end_run();
	end

endmodule

`default_nettype wire

// File: bench/ppu_fsm_asserts.sv
// Concurrent checks of the NTSC timing controller, attached to ppu_fsm with bind from the testbench
`default_nettype none
`timescale 1ns/1ns

module ppu_fsm_asserts (
	input wire logic pclk,
	input wire logic rst_n,
	input wire ppu_fsm_pkg::h_decode_t hdec,
	input wire ppu_fsm_pkg::v_decode_t vdec,
	input wire ppu_fsm_pkg::ppu_ctrl_t ctrl,
	input wire logic reg_read,
	input wire logic dbe,
	input wire ppu_fsm_pkg::sprite_ctrl_t sprite,
	input wire ppu_fsm_pkg::fetch_ctrl_t fetch,
	input wire ppu_fsm_pkg::line_state_t line,
	input wire ppu_fsm_pkg::frame_state_t frame,
	input wire logic sc_cnt,
	input wire logic n_picture,
	input wire logic blnk,
	input wire logic sync,
	input wire logic burst,
	input wire logic hc,
	input wire logic vc,
	input wire logic irq,
	input wire logic db7,
	input wire logic db7_oe
);

	int fail_cnt = 0; // Read by the testbench at the end
	logic blnk_ref; // Blanking flag from vb_set and blnk_clr
	logic pic_ref; // Picture flag, moves only in the back porch
	logic bporch_d; // Back porch one dot late
	logic vclr_q;
	logic odd_ref; // Frame parity, flips one dot after the registered vblank end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			blnk_ref <= 1'b0;
			pic_ref <= 1'b0;
			bporch_d <= 1'b0;
			vclr_q <= 1'b0;
			odd_ref <= 1'b0;
		end else begin
			blnk_ref <= vdec.vb_set | (blnk_ref & ~vdec.blnk_clr);
			if (line.bporch) begin
				pic_ref <= vdec.pic_set | (pic_ref & ~vdec.pic_clr);
			end
			bporch_d <= line.bporch;
			vclr_q <= vdec.vclr;
			odd_ref <= odd_ref ^ vclr_q;
		end
	end

	// Field order n_hb, bporch, fporch, cburst
	a_flags: assert property (@(posedge pclk) disable iff (!rst_n)
		line == ($past({hdec.hb_set, hdec.bp_set, hdec.fp_set, hdec.cb_set})
			| ($past(line) & ~$past({hdec.hb_clr, hdec.bp_clr, hdec.fp_clr, hdec.cb_clr})))
		&& frame.vsync == ($past(line.n_hb)
			? ($past(vdec.vs_set) | ($past(frame.vsync) & ~$past(vdec.vs_clr)))
			: $past(frame.vsync)))
		else begin
			fail_cnt++;
			$error("error %0t: line flag or vsync update wrong", $time);
		end

	a_levels: assert property (@(posedge pclk) disable iff (!rst_n)
		sc_cnt == (line.n_hb & ~ctrl.black)
		&& sync == ~(line.fporch | frame.vsync)
		&& burst == (line.cburst & sync)
		&& blnk == (blnk_ref | ctrl.black)
		&& n_picture == (pic_ref | bporch_d))
		else begin
			fail_cnt++;
			$error("error %0t: scroll, sync, burst, blank or picture level wrong", $time);
		end

	a_events: assert property (@(posedge pclk) disable iff (!rst_n)
		{sprite.s_ev, sprite.z_hpos, sprite.e_ev, sprite.i_oam2, sprite.obj_read}
			== $past({hdec.sev, hdec.hpos, hdec.eev, hdec.ioam, hdec.objrd}, 2)
		&& sprite.n_eval == ~$past(hdec.hpos | hdec.eval | hdec.eev, 2)
		&& {sprite.n_vis, fetch.n_fnt} == ~$past({hdec.nvis, hdec.fnt}, 2)
		&& sprite.clip_o == (!ctrl.n_obclip && $past(hdec.clpo | ~hdec.clpb, 2))
		&& sprite.clip_b == (!ctrl.n_bgclip && $past(hdec.clpo | ~hdec.clpb, 2)))
		else begin
			fail_cnt++;
			$error("error %0t: sprite event or clip output wrong", $time);
		end

	a_fetch: assert property (@(posedge pclk) disable iff (!rst_n)
		fetch.f_at == $past(hdec.fat & ~(hdec.fo_a | hdec.fo_b))
		&& fetch.n_fo == ~$past(hdec.fo_a | hdec.fo_b, 2)
		&& {fetch.f_ta, fetch.f_tb} == ($past({hdec.fta, hdec.ftb}, 2)
			& {2{~$past(hdec.fo_a | hdec.fo_b, 2)}}))
		else begin
			fail_cnt++;
			$error("error %0t: fetch control wrong", $time);
		end

	// Flag sets after vset, clears after vclr or a status read
	a_irq: assert property (@(posedge pclk) disable iff (!rst_n)
		db7 == (!$past(vdec.vclr)
			&& ($past(vdec.vset) || ($past(db7) && !$past(reg_read && dbe))))
		&& irq == (db7 && ctrl.vbl_en)
		&& db7_oe == (reg_read && dbe))
		else begin
			fail_cnt++;
			$error("error %0t: vblank flag, irq or status read wrong", $time);
		end

	a_clear: assert property (@(posedge pclk) disable iff (!rst_n)
		hc == ($past(hdec.h_last) || ($past(hdec.hpos) && $past(odd_ref) && !$past(blnk)))
		&& vc == (hc && $past(vdec.v_last)))
		else begin
			fail_cnt++;
			$error("error %0t: counter clear wrong", $time);
		end

	a_reset: assert property (@(posedge pclk)
		!rst_n |-> (!hc && !vc && !irq && !db7_oe))
		else begin
			fail_cnt++;
			$error("error %0t: output active during reset", $time);
		end

endmodule

`default_nettype wire

// File: verilog/ppu_fsm.sv
// Top of the NTSC picture timing controller, joins horizontal, vertical and frame logic
`default_nettype none
`timescale 1ns/1ns

module ppu_fsm (
	input wire logic pclk,
	input wire logic rst_n,
	input wire ppu_fsm_pkg::h_decode_t hdec,
	input wire ppu_fsm_pkg::v_decode_t vdec,
	input wire ppu_fsm_pkg::ppu_ctrl_t ctrl,
	input wire logic reg_read,
	input wire logic dbe,
	output ppu_fsm_pkg::sprite_ctrl_t sprite,
	output ppu_fsm_pkg::fetch_ctrl_t fetch,
	output logic sc_cnt,
	output logic n_picture,
	output logic blnk,
	output logic sync,
	output logic burst,
	output logic hc,
	output logic vc,
	output logic irq,
	output logic db7,
	output logic db7_oe
);

	ppu_fsm_pkg::line_state_t line; // Horizontal levels
	ppu_fsm_pkg::frame_state_t frame; // Vertical levels and events

	ppu_hpos_logic hpos0 (
		.pclk(pclk),
		.rst_n(rst_n),
		.hdec(hdec),
		.ctrl(ctrl),
		.sprite(sprite),
		.fetch(fetch),
		.line(line),
		.sc_cnt(sc_cnt)
	);

	ppu_vpos_logic vpos0 (
		.pclk(pclk),
		.rst_n(rst_n),
		.vdec(vdec),
		.line(line),
		.black(ctrl.black),
		.frame(frame),
		.blnk_out(blnk)
	);

	ppu_frame_ctrl frame0 (
		.pclk(pclk),
		.rst_n(rst_n),
		.line(line),
		.frame(frame),
		.h_last(hdec.h_last),
		.skip_pt(hdec.hpos), // Skip dot shares the HPos decode
		.v_last(vdec.v_last),
		.vbl_en(ctrl.vbl_en),
		.reg_read(reg_read),
		.dbe(dbe),
		.sync(sync),
		.burst(burst),
		.hc(hc),
		.vc(vc),
		.irq(irq),
		.db7(db7),
		.db7_oe(db7_oe)
	);

	assign n_picture = frame.n_picture;

endmodule

`default_nettype wire

// File: verilog/ppu_frame_ctrl.sv
// Frame controller, builds composite sync, counter clears with odd-frame skip and the vblank IRQ
`default_nettype none
`timescale 1ns/1ns
`include "ppu_fsm_config.svh"

module ppu_frame_ctrl (
	input wire logic pclk,
	input wire logic rst_n,
	input wire ppu_fsm_pkg::line_state_t line,
	input wire ppu_fsm_pkg::frame_state_t frame,
	input wire logic h_last,
	input wire logic skip_pt,
	input wire logic v_last,
	input wire logic vbl_en,
	input wire logic reg_read,
	input wire logic dbe,
	output logic sync,
	output logic burst,
	output logic hc,
	output logic vc,
	output logic irq,
	output logic db7,
	output logic db7_oe
);

	logic parity_q; // High on odd frames
	logic hc_q;
	logic vlast_q;
	logic vbl_q; // Held vblank flag
	logic vbl_flag;
	logic rd_en; // Status register read

	assign sync = ~(line.fporch | frame.vsync); // Active low
	assign burst = line.cburst & sync;

	assign rd_en = reg_read & dbe;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			parity_q <= `PPU_PARITY_RST;
			hc_q <= `PPU_FLAG_RST;
			vlast_q <= `PPU_FLAG_RST;
			vbl_q <= `PPU_FLAG_RST;
		end else begin
			if (frame.rescl) begin
				parity_q <= ~parity_q;
			end
			// Odd rendered frames end the line one dot early
			hc_q <= h_last | (skip_pt & parity_q & ~frame.blnk);
			vlast_q <= v_last;
			if (frame.rescl | rd_en) begin
				vbl_q <= 1'b0;
			end else if (frame.vset_evt) begin
				vbl_q <= 1'b1;
			end
		end
	end

	assign hc = hc_q;
	assign vc = hc_q & vlast_q; // Vertical clear rides on the line clear

	// Events act in their own cycle, the register holds the result
	assign vbl_flag = (vbl_q | frame.vset_evt) & ~frame.rescl;

	assign irq = vbl_flag & vbl_en;
	assign db7 = vbl_flag; // Value before the read clears it
	assign db7_oe = rd_en;

endmodule

`default_nettype wire

// File: verilog/ppu_vpos_logic.sv
// Vertical timing logic, turns V decoder strobes into picture, blanking, vsync and vblank events
`default_nettype none
`timescale 1ns/1ns
`include "ppu_fsm_config.svh"

module ppu_vpos_logic (
	input wire logic pclk,
	input wire logic rst_n,
	input wire ppu_fsm_pkg::v_decode_t vdec,
	input wire ppu_fsm_pkg::line_state_t line,
	input wire logic black,
	output ppu_fsm_pkg::frame_state_t frame,
	output logic blnk_out
);

	logic vsync_q;
	logic pic_q;
	logic bporch_q; // Back porch one dot late
	logic blnk_q;
	logic vset_q;
	logic rescl_q;

	// Vsync only moves inside hblank
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			vsync_q <= `PPU_FLAG_RST;
		end else begin
			vsync_q <= ppu_fsm_pkg::sr_next(line.n_hb & vdec.vs_set,
				line.n_hb & vdec.vs_clr, vsync_q);
		end
	end

	// Picture window moves only in the back porch
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			pic_q <= `PPU_FLAG_RST;
			bporch_q <= `PPU_FLAG_RST;
		end else begin
			pic_q <= ppu_fsm_pkg::sr_next(line.bporch & vdec.pic_set,
				line.bporch & vdec.pic_clr, pic_q);
			bporch_q <= line.bporch;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			blnk_q <= `PPU_FLAG_RST;
			vset_q <= `PPU_FLAG_RST;
			rescl_q <= `PPU_FLAG_RST;
		end else begin
			blnk_q <= ppu_fsm_pkg::sr_next(vdec.vb_set, vdec.blnk_clr, blnk_q);
			vset_q <= vdec.vset; // Vblank start event
			rescl_q <= vdec.vclr; // Vblank end event
		end
	end

	assign blnk_out = blnk_q | black;

	assign frame.vsync = vsync_q;
	assign frame.rescl = rescl_q;
	assign frame.vset_evt = vset_q;
	assign frame.blnk = blnk_out;
	assign frame.n_picture = pic_q | bporch_q;

endmodule

`default_nettype wire

// File: verilog/ppu_hpos_logic.sv
// Horizontal timing logic, turns H decoder strobes into sprite, fetch and line-level controls
`default_nettype none
`timescale 1ns/1ns
`include "ppu_fsm_config.svh"

module ppu_hpos_logic (
	input wire logic pclk,
	input wire logic rst_n,
	input wire ppu_fsm_pkg::h_decode_t hdec,
	input wire ppu_fsm_pkg::ppu_ctrl_t ctrl,
	output ppu_fsm_pkg::sprite_ctrl_t sprite,
	output ppu_fsm_pkg::fetch_ctrl_t fetch,
	output ppu_fsm_pkg::line_state_t line,
	output logic sc_cnt
);

	ppu_fsm_pkg::h_raw_t h_q; // First stage, sampled strobes
	ppu_fsm_pkg::h_decode_t hs;

	// Second stage
	logic s_ev_q;
	logic z_hpos_q;
	logic e_ev_q;
	logic i_oam2_q;
	logic obj_read_q;
	logic n_eval_q;
	logic n_vis_q;
	logic n_fnt_q;
	logic n_fo_q;
	logic f_ta_q;
	logic f_tb_q;
	logic clp_q; // Low while the left columns are clipped

	// Line flags
	logic fporch_q;
	logic bporch_q;
	logic hblank_q;
	logic cburst_q;

	assign hs = ppu_fsm_pkg::h_decode_t'(h_q);

	// Flags follow the raw strobes on the sampling edge
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			fporch_q <= `PPU_FLAG_RST;
			bporch_q <= `PPU_FLAG_RST;
			hblank_q <= `PPU_FLAG_RST;
			cburst_q <= `PPU_FLAG_RST;
		end else begin
			fporch_q <= ppu_fsm_pkg::sr_next(hdec.fp_set, hdec.fp_clr, fporch_q);
			bporch_q <= ppu_fsm_pkg::sr_next(hdec.bp_set, hdec.bp_clr, bporch_q);
			hblank_q <= ppu_fsm_pkg::sr_next(hdec.hb_set, hdec.hb_clr, hblank_q);
			cburst_q <= ppu_fsm_pkg::sr_next(hdec.cb_set, hdec.cb_clr, cburst_q);
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			h_q <= '0;
			s_ev_q <= `PPU_FLAG_RST;
			z_hpos_q <= `PPU_FLAG_RST;
			e_ev_q <= `PPU_FLAG_RST;
			i_oam2_q <= `PPU_FLAG_RST;
			obj_read_q <= `PPU_FLAG_RST;
			n_eval_q <= `PPU_NSTB_RST;
			n_vis_q <= `PPU_NSTB_RST;
			n_fnt_q <= `PPU_NSTB_RST;
			n_fo_q <= `PPU_NSTB_RST;
			f_ta_q <= `PPU_FLAG_RST;
			f_tb_q <= `PPU_FLAG_RST;
			clp_q <= `PPU_FLAG_RST;
		end else begin
			h_q <= hdec;
			s_ev_q <= hs.sev;
			z_hpos_q <= hs.hpos;
			e_ev_q <= hs.eev;
			i_oam2_q <= hs.ioam;
			obj_read_q <= hs.objrd;
			n_eval_q <= ~(hs.hpos | hs.eval | hs.eev); // Evaluation window
			n_vis_q <= ~hs.nvis;
			n_fnt_q <= ~hs.fnt;
			n_fo_q <= ~(hs.fo_a | hs.fo_b);
			f_ta_q <= hs.fta;
			f_tb_q <= hs.ftb;
			clp_q <= ~hs.clpo & hs.clpb;
		end
	end

	assign sprite.s_ev = s_ev_q;
	assign sprite.clip_o = ~(ctrl.n_obclip | clp_q);
	assign sprite.clip_b = ~(ctrl.n_bgclip | clp_q);
	assign sprite.z_hpos = z_hpos_q;
	assign sprite.n_eval = n_eval_q;
	assign sprite.e_ev = e_ev_q;
	assign sprite.i_oam2 = i_oam2_q;
	assign sprite.obj_read = obj_read_q;
	assign sprite.n_vis = n_vis_q;

	assign fetch.n_fnt = n_fnt_q;
	assign fetch.f_tb = f_tb_q & n_fo_q; // Output fetch masks tile fetch
	assign fetch.f_ta = f_ta_q & n_fo_q;
	assign fetch.n_fo = n_fo_q;
	assign fetch.f_at = hs.fat & ~(hs.fo_a | hs.fo_b); // Single stage

	assign line.n_hb = hblank_q;
	assign line.bporch = bporch_q;
	assign line.fporch = fporch_q;
	assign line.cburst = cburst_q;

	assign sc_cnt = hblank_q & ~ctrl.black; // Scroll update only while rendering

endmodule

`default_nettype wire

// File: verilog/ppu_fsm_pkg.sv
// Strobe, control and state types of the NTSC timing controller, referenced by scoped name
`default_nettype none
`include "ppu_fsm_config.svh"

package ppu_fsm_pkg;

	typedef logic [`PPU_HDEC_W-1:0] h_raw_t; // Flat view of the horizontal strobes

	typedef struct packed {
		logic fp_clr; // Front porch
		logic fp_set;
		logic bp_set; // Back porch
		logic bp_clr;
		logic hb_set; // Horizontal blank
		logic hb_clr;
		logic cb_set; // Color burst window
		logic cb_clr;
		logic sev; // Start of sprite evaluation
		logic clpo;
		logic clpb;
		logic hpos;
		logic eval;
		logic eev;
		logic ioam;
		logic objrd;
		logic nvis;
		logic fnt; // Fetch strobes
		logic ftb;
		logic fta;
		logic fo_a;
		logic fo_b;
		logic fat;
		logic h_last; // Last dot of the line
	} h_decode_t;

	typedef struct packed {
		logic vs_clr;
		logic vs_set;
		logic pic_clr;
		logic pic_set;
		logic vb_clr;
		logic vb_set; // Also starts blanking
		logic blnk_clr;
		logic vset; // Vblank start
		logic vclr; // Vblank end
		logic v_last;
	} v_decode_t;

	typedef struct packed {
		logic vbl_en;
		logic n_obclip;
		logic n_bgclip;
		logic black; // Rendering disabled
	} ppu_ctrl_t;

	typedef struct packed {
		logic s_ev;
		logic clip_o;
		logic clip_b;
		logic z_hpos;
		logic n_eval;
		logic e_ev;
		logic i_oam2;
		logic obj_read;
		logic n_vis;
	} sprite_ctrl_t;

	typedef struct packed {
		logic n_fnt;
		logic f_tb;
		logic f_ta;
		logic n_fo;
		logic f_at;
	} fetch_ctrl_t;

	typedef struct packed {
		logic n_hb; // High inside hblank
		logic bporch;
		logic fporch;
		logic cburst;
	} line_state_t;

	typedef struct packed {
		logic vsync;
		logic rescl; // Registered vblank end
		logic vset_evt; // Registered vblank start
		logic blnk;
		logic n_picture;
	} frame_state_t;

	// Next value of a set/reset flag, set has priority
	function automatic logic sr_next(input logic set, input logic clr, input logic q);
		return set | (q & ~clr);
	endfunction

endpackage

`default_nettype wire

// File: verilog/ppu_fsm_config.svh
// Decoder widths and reset levels shared by the timing controller RTL and its testbench
`ifndef PPU_FSM_CONFIG_SVH
`define PPU_FSM_CONFIG_SVH

// Decoder output counts

`define PPU_HDEC_W 24 // Horizontal decoder strobes
`define PPU_VDEC_W 10 // Vertical decoder strobes

// Reset levels

`define PPU_FLAG_RST 1'b0 // Line and frame flags, active-high strobes
`define PPU_NSTB_RST 1'b1 // Active-low strobes idle high
`define PPU_PARITY_RST 1'b0 // First frame is even

`endif
